// File: list.f
verilog/ft245_pkg.sv
verilog/byte_fifo.sv
verilog/ft245_phy_ctrl.sv
verilog/ft245_sync_fifo.sv
test/tb_clock.sv
test/tb_ft245_sync_fifo.sv

// File: Makefile
TOP := tb_ft245_sync_fifo

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_ft245_sync_fifo.sv
// ft245 bridge testbench
`timescale 1ns/1ps

module tb_ft245_sync_fifo;

	localparam int RX_BYTES = 300;
	localparam int TX_BYTES = 300;
	localparam int BP_BYTES = 520;
	localparam int FLUSH_BYTES = 20;
	localparam int TOTAL_BYTES = RX_BYTES + TX_BYTES + BP_BYTES + FLUSH_BYTES;
	localparam real WATCHDOG_NS = (TOTAL_BYTES * 20 + 200) * 100.0;

	logic ftdi_clk;
	logic rst;
	logic in_fifo_rst;
	logic in_fifo_rd;
	logic in_fifo_empty;
	ft245_pkg::byte_t in_fifo_data;
	logic out_fifo_wr;
	logic out_fifo_full;
	ft245_pkg::byte_t out_fifo_data;
	ft245_pkg::byte_t ftdi_data_in;
	ft245_pkg::byte_t ftdi_data_out;
	logic ftdi_txe_n;
	logic ftdi_wr_n;
	logic ftdi_rde_n;
	logic ftdi_rd_n;
	logic ftdi_oe_n;
	logic ftdi_suspend_n;

	// stimulus state
	logic [15:0] gap_lfsr;
	logic [15:0] chip_lfsr;
	int chip_left;
	int tx_left;
	int rx_count;
	int rx_checked;
	int tx_accepted;
	logic chip_advance;
	logic rde_gaps;
	logic txe_stalls;
	logic host_read_en;
	logic rd_pending;
	ft245_pkg::byte_t rx_expect[$];
	ft245_pkg::byte_t tx_expect[$];

	tb_clock clk_gen (
		.ftdi_clk (ftdi_clk),
		.rst      (rst)
	);

	ft245_sync_fifo UUT (
		.ftdi_clk       (ftdi_clk),
		.rst            (rst),
		.in_fifo_rst    (in_fifo_rst),
		.in_fifo_rd     (in_fifo_rd),
		.in_fifo_empty  (in_fifo_empty),
		.in_fifo_data   (in_fifo_data),
		.out_fifo_wr    (out_fifo_wr),
		.out_fifo_full  (out_fifo_full),
		.out_fifo_data  (out_fifo_data),
		.ftdi_data_in   (ftdi_data_in),
		.ftdi_data_out  (ftdi_data_out),
		.ftdi_txe_n     (ftdi_txe_n),
		.ftdi_wr_n      (ftdi_wr_n),
		.ftdi_rde_n     (ftdi_rde_n),
		.ftdi_rd_n      (ftdi_rd_n),
		.ftdi_oe_n      (ftdi_oe_n),
		.ftdi_suspend_n (ftdi_suspend_n)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else report_failure($sformatf(
			"ERR %s expected %0h actual %0h", test_name, expected, actual));
	endtask

	// fibonacci lfsr with taps 16 14 13 11 and one step per bit taken
	function automatic logic [7:0] draw_bits(inout logic [15:0] state, input int n);
		int i;
		draw_bits = '0;
		for (i = 0; i < n; i++) begin
			draw_bits = {draw_bits[6:0], state[15]};
			state = {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
		end
	endfunction

	// drive chip and host on a falling edge and predict the coming rising edge
	task automatic step();
		logic [7:0] r;
		@(negedge ftdi_clk);
		if (chip_advance) begin
			chip_advance = 1'b0;
			chip_left = chip_left - 1;
			ftdi_data_in = draw_bits(chip_lfsr, 8);
		end
		r = draw_bits(gap_lfsr, 2);
		ftdi_rde_n = !(chip_left > 0 && !(rde_gaps && r[1:0] == 2'b11));
		r = draw_bits(gap_lfsr, 2);
		ftdi_txe_n = txe_stalls && r[1:0] == 2'b11;
		// host drain of the data from the previous pulse
		if (rd_pending) begin
			if (rx_expect.size() == 0) begin
				report_failure("host read a byte the chip never sent");
			end else begin
				check_value("rx_order", 32'(rx_expect.pop_front()), 32'(in_fifo_data));
				rx_checked++;
			end
		end
		in_fifo_rd = host_read_en && !in_fifo_empty;
		rd_pending = in_fifo_rd;
		// host fill
		if (tx_left > 0 && !out_fifo_full) begin
			r = draw_bits(gap_lfsr, 8);
			out_fifo_data = r;
			out_fifo_wr = 1'b1;
			tx_expect.push_back(r);
			tx_left--;
		end else begin
			out_fifo_wr = 1'b0;
		end
		// chip strobes stay stable until the coming rising edge
		if (!ftdi_rd_n && !ftdi_rde_n) begin
			rx_expect.push_back(ftdi_data_in);
			rx_count++;
			chip_advance = 1'b1;
		end
		if (!ftdi_wr_n && !ftdi_txe_n) begin
			if (tx_expect.size() == 0) begin
				report_failure("chip accepted a byte the host never wrote");
			end else begin
				check_value("tx_order", 32'(tx_expect.pop_front()), 32'(ftdi_data_out));
				tx_accepted++;
			end
		end
	endtask

	task automatic check_strobes_idle(input string test_name);
		check_value({test_name, "_rd_n"}, 1, 32'(ftdi_rd_n));
		check_value({test_name, "_wr_n"}, 1, 32'(ftdi_wr_n));
		check_value({test_name, "_oe_n"}, 1, 32'(ftdi_oe_n));
	endtask

	// bus rules
	a_read_needs_oe: assert property (
		@(posedge ftdi_clk) disable iff (rst)
		(!ftdi_rd_n && !ftdi_rde_n) |-> !ftdi_oe_n
	) else report_failure("chip data sampled while oe_n was high");

	a_wr_oe_exclusive: assert property (
		@(posedge ftdi_clk) disable iff (rst)
		!(!ftdi_wr_n && !ftdi_oe_n)
	) else report_failure("wr_n and oe_n were low together");

	a_suspend_blocks_read: assert property (
		@(posedge ftdi_clk) disable iff (rst)
		$fell(ftdi_oe_n) |-> $past(ftdi_suspend_n)
	) else report_failure("read burst started while suspend_n was low");

	initial begin
		#(WATCHDOG_NS);
		report_failure("watchdog expired before the tests finished");
	end

	initial begin
		int quiet;
		gap_lfsr = 16'd10;
		chip_lfsr = 16'd10;
		ftdi_data_in = draw_bits(chip_lfsr, 8);
		ftdi_rde_n = 1'b1;
		ftdi_txe_n = 1'b1;
		ftdi_suspend_n = 1'b1;
		in_fifo_rst = 1'b0;
		in_fifo_rd = 1'b0;
		out_fifo_wr = 1'b0;
		out_fifo_data = '0;
		chip_left = 0;
		tx_left = 0;
		rx_count = 0;
		rx_checked = 0;
		tx_accepted = 0;
		chip_advance = 1'b0;
		rde_gaps = 1'b0;
		txe_stalls = 1'b0;
		host_read_en = 1'b0;
		rd_pending = 1'b0;

		// reset values
		@(posedge ftdi_clk);
		repeat (7) begin
			@(negedge ftdi_clk);
			check_strobes_idle("reset");
		end
		wait (!rst);
		step();
		check_strobes_idle("after_reset");
		check_value("after_reset_empty", 1, 32'(in_fifo_empty));
		check_value("after_reset_full", 0, 32'(out_fifo_full));

		// chip to host with rde_n gaps
		rde_gaps = 1'b1;
		host_read_en = 1'b1;
		chip_left = RX_BYTES;
		while (rx_checked < RX_BYTES) step();
		repeat (10) step();

		// host to chip with txe_n stalls
		rde_gaps = 1'b0;
		txe_stalls = 1'b1;
		tx_left = TX_BYTES;
		while (tx_accepted < TX_BYTES) step();
		repeat (10) step();

		// receive back-pressure
		txe_stalls = 1'b0;
		host_read_en = 1'b0;
		rx_count = 0;
		rx_checked = 0;
		chip_left = BP_BYTES;
		quiet = 0;
		while (quiet < 10) begin
			step();
			if (ftdi_rd_n && !in_fifo_empty) begin
				quiet++;
			end else begin
				quiet = 0;
			end
		end
		check_value("backpressure_count", ft245_pkg::FIFO_DEPTH - 1, rx_count);

		// drain with the link suspended so no burst may start
		ftdi_suspend_n = 1'b0;
		host_read_en = 1'b1;
		step();
		while (!in_fifo_empty || rd_pending) begin
			step();
			check_value("suspend_oe_n", 1, 32'(ftdi_oe_n));
		end
		check_value("drained_count", ft245_pkg::FIFO_DEPTH - 1, rx_checked);
		ftdi_suspend_n = 1'b1;
		while (rx_checked < BP_BYTES) step();

		// flush of the receive FIFO
		host_read_en = 1'b0;
		rx_count = 0;
		chip_left = FLUSH_BYTES;
		while (rx_count < FLUSH_BYTES) step();
		repeat (4) step();
		check_value("flush_before_empty", 0, 32'(in_fifo_empty));
		in_fifo_rst = 1'b1;
		step();
		in_fifo_rst = 1'b0;
		rx_expect.delete();
		check_value("flush_empty", 1, 32'(in_fifo_empty));
		repeat (2) step();

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: test/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD = 100.0,
	parameter int RESET_CYCLES = 8
) (
	output logic ftdi_clk,
	output logic rst
);

	initial begin
		ftdi_clk = 1'b0;
		forever #(PERIOD / 2.0) ftdi_clk = ~ftdi_clk;
	end

	// release on a falling edge, like every other input
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge ftdi_clk);
		@(negedge ftdi_clk);
		rst = 1'b0;
	end

endmodule

// File: verilog/ft245_sync_fifo.sv
// ft245 synchronous FIFO bridge
`timescale 1ns/1ps

module ft245_sync_fifo (
	input  logic             ftdi_clk,
	input  logic             rst,

	// host receive side
	input  logic             in_fifo_rst,
	input  logic             in_fifo_rd,
	output logic             in_fifo_empty,
	output ft245_pkg::byte_t in_fifo_data,

	// host transmit side
	input  logic             out_fifo_wr,
	output logic             out_fifo_full,
	input  ft245_pkg::byte_t out_fifo_data,

	// chip side, bus split into both directions
	input  ft245_pkg::byte_t ftdi_data_in,
	output ft245_pkg::byte_t ftdi_data_out,
	input  logic             ftdi_txe_n,
	output logic             ftdi_wr_n,
	input  logic             ftdi_rde_n,
	output logic             ftdi_rd_n,
	output logic             ftdi_oe_n,
	input  logic             ftdi_suspend_n
);

	// controller to rx FIFO
	logic             rx_wr;
	ft245_pkg::byte_t rx_data;
	logic             rx_full;

	// tx FIFO to controller
	logic             tx_rd;
	ft245_pkg::byte_t tx_data;
	logic             tx_empty;

	// chip to host, host can flush it on its own
	byte_fifo rx_fifo (
		.ftdi_clk (ftdi_clk),
		.rst      (rst),
		.flush    (in_fifo_rst),
		.wr       (rx_wr),
		.wr_data  (rx_data),
		.rd       (in_fifo_rd),
		.rd_data  (in_fifo_data),
		.full     (rx_full),
		.empty    (in_fifo_empty)
	);

	// host to chip
	byte_fifo tx_fifo (
		.ftdi_clk (ftdi_clk),
		.rst      (rst),
		.flush    (1'b0),
		.wr       (out_fifo_wr),
		.wr_data  (out_fifo_data),
		.rd       (tx_rd),
		.rd_data  (tx_data),
		.full     (out_fifo_full),
		.empty    (tx_empty)
	);

	ft245_phy_ctrl phy (
		.ftdi_clk       (ftdi_clk),
		.rst            (rst),
		.ftdi_rde_n     (ftdi_rde_n),
		.ftdi_txe_n     (ftdi_txe_n),
		.ftdi_suspend_n (ftdi_suspend_n),
		.ftdi_data_in   (ftdi_data_in),
		.ftdi_rd_n      (ftdi_rd_n),
		.ftdi_wr_n      (ftdi_wr_n),
		.ftdi_oe_n      (ftdi_oe_n),
		.ftdi_data_out  (ftdi_data_out),
		.rx_wr          (rx_wr),
		.rx_data        (rx_data),
		.rx_full        (rx_full),
		.tx_rd          (tx_rd),
		.tx_data        (tx_data),
		.tx_empty       (tx_empty)
	);

endmodule

// File: verilog/ft245_phy_ctrl.sv
// ft245 phy controller
`timescale 1ns/1ps

module ft245_phy_ctrl (
	input  logic             ftdi_clk,
	input  logic             rst,

	// chip side
	input  logic             ftdi_rde_n,
	input  logic             ftdi_txe_n,
	input  logic             ftdi_suspend_n,
	input  ft245_pkg::byte_t ftdi_data_in,
	output logic             ftdi_rd_n,
	output logic             ftdi_wr_n,
	output logic             ftdi_oe_n,
	output ft245_pkg::byte_t ftdi_data_out,

	// receive FIFO write port
	output logic             rx_wr,
	output ft245_pkg::byte_t rx_data,
	input  logic             rx_full,

	// transmit FIFO read port
	output logic             tx_rd,
	input  ft245_pkg::byte_t tx_data,
	input  logic             tx_empty
);

	ft245_pkg::phy_state_t state;

	logic rd_start;
	logic wr_start;
	logic wr_accept;
	logic wr_more;

	// chip has data, we have room and the link is awake
	assign rd_start = !ftdi_rde_n && !rx_full && ftdi_suspend_n;

	// chip can take data and we have some to give
	assign wr_start = !ftdi_txe_n && !tx_empty && ftdi_suspend_n;

	// byte taken by the chip at this edge
	assign wr_accept = (state == ft245_pkg::WRITE) && !ftdi_wr_n && !ftdi_txe_n;

	// keep streaming unless the tx FIFO drained or the chip wants to send
	assign wr_more = wr_accept && !tx_empty && ftdi_rde_n;

	// every edge with rd_n and rde_n low hands over exactly one byte
	assign rx_wr = !ftdi_rd_n && !ftdi_rde_n;
	assign rx_data = ftdi_data_in;

	// tx FIFO output register holds the byte on the bus,
	// it only moves on tx_rd so a txe_n stall keeps it in place
	assign tx_rd = (state == ft245_pkg::WRITE_FETCH) || wr_more;
	assign ftdi_data_out = tx_data;

	always_ff @(posedge ftdi_clk) begin
		if (rst) begin
			state <= ft245_pkg::IDLE;
			ftdi_rd_n <= 1'b1;
			ftdi_wr_n <= 1'b1;
			ftdi_oe_n <= 1'b1;
		end else begin
			case (state)
				ft245_pkg::IDLE: begin
					// reads win over writes
					if (rd_start) begin
						ftdi_oe_n <= 1'b0;
						state <= ft245_pkg::READ_OE;
					end else if (wr_start) begin
						state <= ft245_pkg::WRITE_FETCH;
					end
				end

				ft245_pkg::READ_OE: begin
					// one turnaround cycle between oe_n and rd_n
					ftdi_rd_n <= 1'b0;
					state <= ft245_pkg::READ;
				end

				ft245_pkg::READ: begin
					if (ftdi_rde_n || rx_full) begin
						// chip ran dry or rx FIFO near full
						ftdi_rd_n <= 1'b1;
						ftdi_oe_n <= 1'b1;
						state <= ft245_pkg::IDLE;
					end else begin
						ftdi_rd_n <= 1'b0;
					end
				end

				ft245_pkg::WRITE_FETCH: begin
					// byte shows up on the bus next cycle
					ftdi_wr_n <= ftdi_txe_n;
					state <= ft245_pkg::WRITE;
				end

				ft245_pkg::WRITE: begin
					if (wr_accept) begin
						if (wr_more) begin
							ftdi_wr_n <= 1'b0;
						end else begin
							ftdi_wr_n <= 1'b1;
							state <= ft245_pkg::IDLE;
						end
					end else begin
						// stalled, hold the byte and strobe again once txe_n drops
						ftdi_wr_n <= ftdi_txe_n;
					end
				end

				default: begin
					ftdi_rd_n <= 1'b1;
					ftdi_wr_n <= 1'b1;
					ftdi_oe_n <= 1'b1;
					state <= ft245_pkg::IDLE;
				end
			endcase
		end
	end

	// rd_n only low after oe_n has already turned the bus around
	a_rd_after_oe: assert property (
		@(posedge ftdi_clk) disable iff (rst)
		!ftdi_rd_n |-> (!ftdi_oe_n && $past(!ftdi_oe_n))
	) else $error("ft245_phy_ctrl: rd_n low without oe_n turnaround");

	// never strobe a write while the chip drives the bus
	a_no_bus_fight: assert property (
		@(posedge ftdi_clk) disable iff (rst)
		!ftdi_wr_n |-> ftdi_oe_n
	) else $error("ft245_phy_ctrl: wr_n and oe_n both low");

	// tx_empty cannot rise between the check in IDLE and the fetch
	a_tx_rd_not_empty: assert property (
		@(posedge ftdi_clk) disable iff (rst)
		tx_rd |-> !tx_empty
	) else $error("ft245_phy_ctrl: tx_rd while tx FIFO empty");

endmodule

// File: verilog/byte_fifo.sv
// synchronous byte FIFO
`timescale 1ns/1ps

module byte_fifo (
	input  logic             ftdi_clk,
	input  logic             rst,
	input  logic             flush,
	input  logic             wr,
	input  ft245_pkg::byte_t wr_data,
	input  logic             rd,
	output ft245_pkg::byte_t rd_data,
	output logic             full,
	output logic             empty
);

	ft245_pkg::byte_t mem [0:ft245_pkg::FIFO_DEPTH-1];

	ft245_pkg::fifo_ptr_t wr_ptr;
	ft245_pkg::fifo_ptr_t rd_ptr;
	ft245_pkg::fifo_ptr_t level;

	// occupancy, wraps cleanly thanks to the extra pointer bit
	assign level = wr_ptr - rd_ptr;

	// flags follow the pointers, so they move one cycle after the access
	assign empty = (level == '0);
	assign full = (level >= ft245_pkg::FIFO_FULL_LEVEL);

	// pointer update, flush drops all stored bytes
	always_ff @(posedge ftdi_clk) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge ftdi_clk) begin
		if (wr) begin
			mem[wr_ptr[ft245_pkg::FIFO_ADDR_W-1:0]] <= wr_data;
		end
	end

	// registered read port, data valid the cycle after rd
	always_ff @(posedge ftdi_clk) begin
		if (rd) begin
			rd_data <= mem[rd_ptr[ft245_pkg::FIFO_ADDR_W-1:0]];
		end
	end

	// once full is up at most the single in-flight byte may still land
	a_no_write_when_full: assert property (
		@(posedge ftdi_clk) disable iff (rst || flush)
		(wr && full) |=> !wr
	) else $error("byte_fifo: write burst continued past full");

	// the storage itself must never overflow
	a_no_overflow: assert property (
		@(posedge ftdi_clk) disable iff (rst || flush)
		wr |-> (level != ft245_pkg::fifo_ptr_t'(ft245_pkg::FIFO_DEPTH))
	) else $error("byte_fifo: write with no free slot");

	// readers must watch empty
	a_no_read_when_empty: assert property (
		@(posedge ftdi_clk) disable iff (rst || flush)
		rd |-> !empty
	) else $error("byte_fifo: read while empty");

endmodule

// File: verilog/ft245_pkg.sv
// ft245 bridge shared definitions
package ft245_pkg;

	// one byte on the chip bus and in both FIFOs
	typedef logic [7:0] byte_t;

	// FIFO geometry
	localparam int FIFO_ADDR_W = 9;
	localparam int FIFO_DEPTH = 2 ** FIFO_ADDR_W;

	// extra msb tells a full FIFO from an empty one
	typedef logic [FIFO_ADDR_W:0] fifo_ptr_t;

	// full rises early so the byte still strobed in by the chip has a slot.
	// the rx side therefore never holds more than FIFO_DEPTH - 1 bytes
	localparam fifo_ptr_t FIFO_FULL_LEVEL = fifo_ptr_t'(FIFO_DEPTH - 2);

	// phy controller states
	typedef enum logic [2:0] {
		IDLE,
		READ_OE,
		READ,
		WRITE_FETCH,
		WRITE
	} phy_state_t;

endpackage
